// ==== hw/sdramPkg.sv ====
//////////////////////////////
// Shared definitions for the SDRAM write command generator
// Timing constants in sclk cycles
// ROB and write-data buffer field layout
// Command, operation and FSM state enums
// Command queue entry type
//////////////////////////////
package sdramPkg;

    // Field widths
    localparam int BankW    = 2;
    localparam int RowW     = 11;
    localparam int ColW     = 8;
    localparam int DataW    = 32;
    localparam int MaskW    = 4;
    localparam int RobW     = 36;
    localparam int QwdW     = 36;
    localparam int QwdAddrW = 5;

    // ROB word layout, low to high
    localparam int ColLsb  = 0;
    localparam int RowLsb  = ColLsb + ColW;   // 8
    localparam int BankLsb = RowLsb + RowW;   // 19
    localparam int OpLsb   = BankLsb + BankW; // 21
    localparam int OpW     = 2;

    localparam int QwdAddrLsb = 2;            // Buffer address is col[6:2]

    localparam int QueueDepth = 16;
    localparam int QueueAddrW = 4;

    // SDRAM timing
    localparam int tRcd    = 3;               // ACT to WR
    localparam int tWr     = 2;
    localparam int tCp     = 6;               // WR to PRE is tWr + tCp
    localparam int tRp     = 3;               // PRE to next ACT or REFRESH
    localparam int tRfcDur = 9;               // REFRESH to next command
    localparam int tRefi   = 4686;            // 15.6 us at 300 MHz

    localparam int TimerW  = 4;
    localparam int RefCntW = 13;

    localparam logic [RowW-1:0] PreAllAddr = 11'h400;  // A10 high

    typedef enum logic [OpW-1:0] {
        OpWrite = 2'b01,
        OpRead  = 2'b10
    } robOpE;

    typedef enum logic [2:0] {
        CmdNop     = 3'b000,
        CmdAct     = 3'b001,
        CmdWr      = 3'b011,
        CmdPreAll  = 3'b100,
        CmdPreBank = 3'b101,
        CmdRefresh = 3'b110
    } sdramCmdE;

    typedef enum logic [1:0] {FetchIdle, FetchRead, FetchCapture, FetchAck} fetchStateE;

    typedef enum logic [2:0] {
        SeqInit, SeqIdle, SeqAct, SeqWrite, SeqHold, SeqPre, SeqRefresh
    } seqStateE;

    typedef struct packed {
        logic [BankW-1:0] bank;
        logic [RowW-1:0]  row;
        logic [ColW-1:0]  col;
    } writeReqT;

endpackage

// ==== hw/sdramCmdIf.sv ====
//////////////////////////////
// One SDRAM command with its address and write data
// src side is the sequencer, dst side the pin encoder
//////////////////////////////
`timescale 1ns/10ps

interface sdramCmdIf;
    import sdramPkg::*;

    sdramCmdE          cmd;
    logic [BankW-1:0]  bank;
    logic [RowW-1:0]   addr;   // Row for ACT, col for WR, A10 for precharge
    logic [DataW-1:0]  dq;
    logic [MaskW-1:0]  dqm;

    modport src (
        output cmd, bank, addr, dq, dqm
    );

    modport dst (
        input cmd, bank, addr, dq, dqm
    );

endinterface

// ==== hw/requestFetch.sv ====
//////////////////////////////
// ROB pop FSM
// Slices the ROB word and pushes write requests into the queue
// Reads and unknown operations are dropped
//////////////////////////////
`timescale 1ns/10ps

module requestFetch (
    input  logic                        sclk,
    input  logic                        sresetn,
    input  logic                        robEmpty,
    output logic                        robRd,
    input  logic [sdramPkg::RobW-1:0]   robRdData,
    output logic                        push,
    output sdramPkg::writeReqT          pushData,
    input  logic                        full
);
    import sdramPkg::*;

    fetchStateE state;
    logic       isWrite;
    writeReqT   req;

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            state   <= FetchIdle;
            isWrite <= 1'b0;
        end else begin
            case (state)
                FetchIdle:    if (!robEmpty && !full) state <= FetchRead;
                FetchRead:    state <= FetchCapture;
                FetchCapture: begin
                    isWrite <= (robRdData[OpLsb +: OpW] == OpWrite);
                    state   <= FetchAck;
                end
                default:      state <= FetchIdle;  // Ack gives robEmpty time to update
            endcase
        end
    end

    // ROB data is valid only in the capture cycle
    always_ff @(posedge sclk) begin
        if (state == FetchCapture) begin
            req.bank <= robRdData[BankLsb +: BankW];
            req.row  <= robRdData[RowLsb +: RowW];
            req.col  <= robRdData[ColLsb +: ColW];
        end
    end

    assign robRd    = (state == FetchRead);
    assign push     = (state == FetchAck) && isWrite;
    assign pushData = req;

    // Full was checked at pop time and the queue cannot fill in between
    assert property (@(posedge sclk) disable iff (!sresetn) push |-> !full);

endmodule

// ==== hw/cmdQueue.sv ====
//////////////////////////////
// Show-ahead synchronous FIFO of write requests
// Circular buffer with read and write pointers and a count
//////////////////////////////
`timescale 1ns/10ps

module cmdQueue (
    input  logic               sclk,
    input  logic               sresetn,
    input  logic               push,
    input  sdramPkg::writeReqT pushData,
    input  logic               pop,
    output sdramPkg::writeReqT popData,
    output logic               full,
    output logic               empty
);
    import sdramPkg::*;

    writeReqT              mem [QueueDepth];
    logic [QueueAddrW-1:0] wrPtr;
    logic [QueueAddrW-1:0] rdPtr;
    logic [QueueAddrW:0]   count;

    always_ff @(posedge sclk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;  // Wraps at QueueDepth
            if (pop)  rdPtr <= rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry is visible before the pop
    assign popData = mem[rdPtr];
    assign full    = (count == (QueueAddrW + 1)'(QueueDepth));
    assign empty   = (count == '0);

    assert property (@(posedge sclk) disable iff (!sresetn) pop |-> !empty);
    assert property (@(posedge sclk) disable iff (!sresetn) push |-> !full);

endmodule

// ==== hw/accessSequencer.sv ====
//////////////////////////////
// Close-row write sequencer
// PRECHARGE ALL after reset, then ACT, WR, PRE per write
// Phase timer, refresh interval counter and data buffer read
//////////////////////////////
`timescale 1ns/10ps

module accessSequencer (
    input  logic                            sclk,
    input  logic                            sresetn,
    output logic                            pop,
    input  sdramPkg::writeReqT              popData,
    input  logic                            empty,
    output logic                            qwdRd,
    output logic [sdramPkg::QwdAddrW-1:0]   qwdRdAddr,
    input  logic [sdramPkg::QwdW-1:0]       qwdRdData,
    sdramCmdIf.src                          cmdOut
);
    import sdramPkg::*;

    seqStateE           state;
    sdramCmdE           cmdQ;       // Command on the interface this cycle
    logic [TimerW-1:0]  timer;
    logic               timerDone;
    logic [RefCntW-1:0] refCnt;
    logic               refPending;
    logic               refServe;
    logic [BankW-1:0]   curBank;
    logic [RowW-1:0]    curRow;
    logic [ColW-1:0]    curCol;
    logic [RowW-1:0]    addrMux;

    assign timerDone = (timer == '0);

    // Refresh has priority over a waiting write
    assign refServe = (state == SeqIdle) && refPending;
    assign pop      = (state == SeqIdle) && !refPending && !empty;

    // Entry held for the whole sequence
    always_ff @(posedge sclk) begin
        if (pop) begin
            curBank <= popData.bank;
            curRow  <= popData.row;
            curCol  <= popData.col;
        end
    end

    // Refresh interval, reloaded when the REFRESH goes out
    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            refCnt     <= RefCntW'(tRefi);
            refPending <= 1'b0;
        end else if (refServe) begin
            refCnt     <= RefCntW'(tRefi);
            refPending <= 1'b0;
        end else if (refCnt == '0) begin
            refPending <= 1'b1;
        end else begin
            refCnt <= refCnt - 1'b1;
        end
    end

    // Commands are decided one cycle ahead and appear with the new state
    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            state <= SeqInit;
            cmdQ  <= CmdPreAll;               // First command after reset
            timer <= TimerW'(tRp - 1);
            qwdRd <= 1'b0;
        end else begin
            cmdQ  <= CmdNop;
            qwdRd <= 1'b0;
            timer <= timerDone ? timer : timer - 1'b1;
            case (state)
                SeqInit, SeqPre, SeqRefresh: begin
                    if (timerDone) state <= SeqIdle;
                end
                SeqIdle: begin
                    if (refServe) begin
                        cmdQ  <= CmdRefresh;
                        timer <= TimerW'(tRfcDur - 2);
                        state <= SeqRefresh;
                    end else if (pop) begin
                        cmdQ  <= CmdAct;
                        timer <= TimerW'(tRcd - 2);
                        state <= SeqAct;
                    end
                end
                SeqAct: begin
                    if (timerDone) begin
                        qwdRd <= 1'b1;        // Data returns with the WR
                        state <= SeqWrite;
                    end
                end
                SeqWrite: begin
                    cmdQ  <= CmdWr;
                    timer <= TimerW'(tWr + tCp - 1);
                    state <= SeqHold;
                end
                SeqHold: begin
                    if (timerDone) begin
                        cmdQ  <= CmdPreBank;
                        timer <= TimerW'(tRp - 1);
                        state <= SeqPre;
                    end
                end
                default: state <= SeqIdle;
            endcase
        end
    end

    always_comb begin
        case (cmdQ)
            CmdAct:                addrMux = curRow;
            CmdWr:                 addrMux = RowW'(curCol);
            CmdPreAll, CmdPreBank: addrMux = PreAllAddr;
            default:               addrMux = '0;
        endcase
    end

    assign qwdRdAddr   = curCol[QwdAddrLsb +: QwdAddrW];

    assign cmdOut.cmd  = cmdQ;
    assign cmdOut.bank = curBank;
    assign cmdOut.addr = addrMux;
    assign cmdOut.dq   = qwdRdData[QwdW-1 -: DataW];  // Mask sits below the data
    assign cmdOut.dqm  = qwdRdData[MaskW-1:0];

    // Row must be open exactly tRcd before the column write
    assert property (@(posedge sclk) disable iff (!sresetn)
        (cmdOut.cmd == CmdAct) |-> ##tRcd (cmdOut.cmd == CmdWr));

endmodule

// ==== hw/pinEncoder.sv ====
//////////////////////////////
// SDRAM pin register
// Maps a command to CS RAS CAS WE levels
// Write data and mask only with WR
//////////////////////////////
`timescale 1ns/10ps

module pinEncoder (
    input  logic                         sclk,
    input  logic                         sresetn,
    sdramCmdIf.dst                       cmdIn,
    output logic                         clkEn,
    output logic                         csn,
    output logic                         rasn,
    output logic                         casn,
    output logic                         wen,
    output logic [sdramPkg::MaskW-1:0]   dqm,
    output logic [sdramPkg::BankW-1:0]   bank,
    output logic [sdramPkg::RowW-1:0]    addr,
    output logic [sdramPkg::DataW-1:0]   dq
);
    import sdramPkg::*;

    logic [3:0] ctl;       // {csn, rasn, casn, wen}
    logic       isWr;
    logic       bankUsed;

    always_comb begin
        case (cmdIn.cmd)
            CmdPreAll, CmdPreBank: ctl = 4'b0010;
            CmdAct:                ctl = 4'b0011;
            CmdWr:                 ctl = 4'b0100;
            CmdRefresh:            ctl = 4'b0001;
            default:               ctl = 4'b0111;  // NOP
        endcase
    end

    assign isWr     = (cmdIn.cmd == CmdWr);
    assign bankUsed = (cmdIn.cmd == CmdAct) || isWr || (cmdIn.cmd == CmdPreBank);

    always_ff @(posedge sclk or negedge sresetn) begin
        if (!sresetn) begin
            clkEn <= 1'b0;
            {csn, rasn, casn, wen} <= 4'b1111;
            dqm   <= '0;
            bank  <= '0;
            addr  <= '0;
            dq    <= '0;
        end else begin
            clkEn <= 1'b1;
            {csn, rasn, casn, wen} <= ctl;
            dqm   <= isWr ? cmdIn.dqm : '0;
            dq    <= isWr ? cmdIn.dq : '0;
            bank  <= bankUsed ? cmdIn.bank : '0;
            addr  <= cmdIn.addr;
        end
    end

endmodule

// ==== hw/sdramCmdGen.sv ====
//////////////////////////////
// SDRAM write command generator top
// ROB fetch, command queue, sequencer and pin encoder
//////////////////////////////
`timescale 1ns/10ps

module sdramCmdGen (
    input  logic                            sclk,
    input  logic                            sresetn,
    input  logic                            robEmpty,
    output logic                            robRd,
    input  logic [sdramPkg::RobW-1:0]       robRdData,
    output logic                            qwdRd,
    output logic [sdramPkg::QwdAddrW-1:0]   qwdRdAddr,
    input  logic [sdramPkg::QwdW-1:0]       qwdRdData,
    output logic                            clkEn,
    output logic                            csn,
    output logic                            rasn,
    output logic                            casn,
    output logic                            wen,
    output logic [sdramPkg::MaskW-1:0]      dqm,
    output logic [sdramPkg::BankW-1:0]      bank,
    output logic [sdramPkg::RowW-1:0]       addr,
    output logic [sdramPkg::DataW-1:0]      dq
);
    import sdramPkg::*;

    logic     push;
    writeReqT pushData;
    logic     pop;
    writeReqT popData;
    logic     full;
    logic     empty;

    sdramCmdIf cmdIf_i ();

    requestFetch requestFetch_i (
        .sclk, .sresetn, .robEmpty, .robRd, .robRdData, .push, .pushData, .full
    );

    cmdQueue cmdQueue_i (
        .sclk, .sresetn, .push, .pushData, .pop, .popData, .full, .empty
    );

    accessSequencer accessSequencer_i (
        .sclk, .sresetn, .pop, .popData, .empty, .qwdRd, .qwdRdAddr, .qwdRdData,
        .cmdOut (cmdIf_i.src)
    );

    pinEncoder pinEncoder_i (
        .sclk, .sresetn,
        .cmdIn (cmdIf_i.dst),
        .clkEn, .csn, .rasn, .casn, .wen, .dqm, .bank, .addr, .dq
    );

endmodule

// ==== dv/sdramChecker.sv ====
//////////////////////////////
// SDRAM pin monitor and scoreboard
// Decodes CS RAS CAS WE and compares with expected commands
// ACT WR PRE spacing and refresh rules
// Per-test result lines and the closing counts
//////////////////////////////
`timescale 1ns/10ps

module sdramChecker (
    input  logic                          sclk,
    input  logic                          sresetn,
    input  logic                          robRd,
    input  logic                          qwdRd,
    input  logic                          clkEn,
    input  logic                          csn,
    input  logic                          rasn,
    input  logic                          casn,
    input  logic                          wen,
    input  logic [sdramPkg::MaskW-1:0]    dqm,
    input  logic [sdramPkg::BankW-1:0]    bank,
    input  logic [sdramPkg::RowW-1:0]     addr,
    input  logic [sdramPkg::DataW-1:0]    dq
);
    import sdramPkg::*;

    localparam logic [3:0] CtlNop = 4'b0111;
    localparam logic [3:0] CtlPre = 4'b0010;  // Bank precharge and precharge all
    localparam logic [3:0] CtlAct = 4'b0011;
    localparam logic [3:0] CtlWr  = 4'b0100;
    localparam logic [3:0] CtlRef = 4'b0001;

    // Counter reload and pending flag add two cycles, then at most one sequence
    localparam int RefGapMax = tRefi + 2 + tRcd + tWr + tCp + tRp + 1;

    logic [52:0] expQ[$];              // {ctl, bank, addr, dq, dqm}
    string       testName   = "reset";
    int          testErrors = 0;
    int          testCmds   = 0;
    int          testRefs   = 0;
    int          testsRun   = 0;
    int          testsFailed = 0;
    int          errors     = 0;
    int          refreshes  = 0;
    int          cycle      = 0;
    int          lastAct    = -100;
    int          lastWr     = -100;
    int          lastPre    = -100;
    int          lastRef    = -100;
    logic        rowOpen    = 1'b0;
    logic        seenRef    = 1'b0;
    logic [3:0]  ctl;

    assign ctl = {csn, rasn, casn, wen};

    task automatic reportFailure(string msg);
        $display("%s: %s", testName, msg);
        errors++;
        testErrors++;
    endtask

    task automatic compareField(string field, logic [31:0] expVal, logic [31:0] actVal);
        if (expVal !== actVal) begin
            $display("error %s %s expected %h actual %h", testName, field, expVal, actVal);
            errors++;
            testErrors++;
        end
    endtask

    task automatic expectCmd(logic [3:0] ctlExp, logic [BankW-1:0] bankExp,
                             logic [RowW-1:0] addrExp, logic [DataW-1:0] dqExp,
                             logic [MaskW-1:0] dqmExp);
        expQ.push_back({ctlExp, bankExp, addrExp, dqExp, dqmExp});
    endtask

    task automatic checkTiming();
        if (cycle - lastRef < tRfcDur) reportFailure("command too soon after REFRESH");
        case (ctl)
            CtlAct: begin
                if (rowOpen) reportFailure("ACT while a row is still open");
                if (cycle - lastPre < tRp) reportFailure("ACT too soon after PRE");
                rowOpen = 1'b1;
                lastAct = cycle;
            end
            CtlWr: begin
                if (!rowOpen || cycle - lastAct != tRcd) reportFailure("WR not tRcd after ACT");
                lastWr = cycle;
            end
            CtlPre: begin
                if (rowOpen && cycle - lastWr != tWr + tCp)
                    reportFailure("PRE not tWr plus tCp after WR");
                rowOpen = 1'b0;
                lastPre = cycle;
            end
            CtlRef: begin
                if (rowOpen) reportFailure("REFRESH between ACT and PRE");
                if (cycle - lastPre < tRp) reportFailure("REFRESH too soon after PRE");
                if (seenRef && cycle - lastRef > RefGapMax) reportFailure("refresh gap too long");
                seenRef = 1'b1;
                lastRef = cycle;
                refreshes++;
                testRefs++;
            end
            default: reportFailure("unknown control pattern on the pins");
        endcase
    endtask

    task automatic compareNext();
        logic [52:0] exp;
        if (expQ.size() == 0) begin
            reportFailure("command on the pins with nothing expected");
        end else begin
            exp = expQ.pop_front();
            testCmds++;
            compareField("command", 32'(exp[52:49]), 32'(ctl));
            compareField("bank", 32'(exp[48:47]), 32'(bank));
            compareField("addr", 32'(exp[46:36]), 32'(addr));
            compareField("dq", exp[35:4], dq);
            compareField("dqm", 32'(exp[3:0]), 32'(dqm));
        end
    endtask

    // Pins settle after the rising edge, sampled mid-cycle
    always @(negedge sclk) begin
        cycle++;
        if (!sresetn) begin
            if (clkEn || robRd || qwdRd || ctl != 4'b1111 || dqm != '0 || bank != '0
                    || addr != '0 || dq != '0)
                reportFailure("pins not inactive during reset");
        end else if (!clkEn) begin
            reportFailure("clock enable low after reset");
        end else if (ctl != CtlNop) begin
            checkTiming();
            if (ctl != CtlRef) compareNext();
        end
    end

    task automatic beginTest(string name);
        testName   = name;
        testErrors = 0;
        testCmds   = 0;
        testRefs   = 0;
    endtask

    task automatic endTest();
        testsRun++;
        if (testErrors != 0) testsFailed++;
        $display("test %-10s %s  commands %0d  refreshes %0d  errors %0d", testName,
                 (testErrors == 0) ? "pass" : "fail", testCmds, testRefs, testErrors);
    endtask

    task automatic printSummary();
        $display("tests %0d  failed %0d  errors %0d  refreshes %0d  unmatched %0d",
                 testsRun, testsFailed, errors, refreshes, expQ.size());
    endtask

    function automatic int pending();
        return expQ.size();
    endfunction

    function automatic int errorTotal();
        return errors + expQ.size();  // Leftover expectations count as lost commands
    endfunction

    function automatic int refreshTotal();
        return refreshes;
    endfunction

endmodule

// ==== dv/tbSdramCmdGen.sv ====
//////////////////////////////
// Testbench for the SDRAM write command generator
// Clock, reset, ROB and write-data buffer models
// Request table applied in a loop, cycle timeout
//////////////////////////////
`timescale 1ns/10ps

module tbSdramCmdGen;
    import sdramPkg::*;

    localparam int NumRows   = 9;
    localparam int SeqCycles = tRcd + tWr + tCp + tRp + 1;  // ACT to next ACT
    localparam int PopCycles = 4;                           // ROB handshake per entry

    logic                sclk;
    logic                sresetn;
    logic                robEmpty;
    logic                robRd;
    logic [RobW-1:0]     robRdData;
    logic                qwdRd;
    logic [QwdAddrW-1:0] qwdRdAddr;
    logic [QwdW-1:0]     qwdRdData;
    logic                clkEn;
    logic                csn;
    logic                rasn;
    logic                casn;
    logic                wen;
    logic [MaskW-1:0]    dqm;
    logic [BankW-1:0]    bank;
    logic [RowW-1:0]     addr;
    logic [DataW-1:0]    dq;

    // Request table, rows of one test are adjacent
    string            rowName [NumRows];
    int               rowCount[NumRows];
    logic [1:0]       rowOp   [NumRows];
    logic [BankW-1:0] rowBank [NumRows];
    logic [RowW-1:0]  rowRow  [NumRows];
    logic [ColW-1:0]  rowCol  [NumRows];

    logic [QwdW-1:0]     bufWord [32];
    logic [RobW-1:0]     robQ[$];
    logic                robDue      = 1'b0;  // Pop was seen on the last falling edge
    logic                qwdDue      = 1'b0;
    logic [QwdAddrW-1:0] qwdAddrHeld = '0;
    int                  cycles = 0;
    int                  limit  = 0;

    sdramCmdGen sdramCmdGen_i (
        .sclk, .sresetn, .robEmpty, .robRd, .robRdData, .qwdRd, .qwdRdAddr, .qwdRdData,
        .clkEn, .csn, .rasn, .casn, .wen, .dqm, .bank, .addr, .dq
    );

    sdramChecker sdramChecker_i (
        .sclk, .sresetn, .robRd, .qwdRd,
        .clkEn, .csn, .rasn, .casn, .wen, .dqm, .bank, .addr, .dq
    );

    always #4 sclk = ~sclk;

    function automatic logic [31:0] lcgNext(logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic setRow(int i, string name, int count, logic [1:0] op,
                          logic [BankW-1:0] b, logic [RowW-1:0] r, logic [ColW-1:0] c);
        rowName[i]  = name;
        rowCount[i] = count;
        rowOp[i]    = op;
        rowBank[i]  = b;
        rowRow[i]   = r;
        rowCol[i]   = c;
    endtask

    // Request k of a row steps bank, row and buffer address
    task automatic sendRequest(int i, int k);
        logic [BankW-1:0] b;
        logic [RowW-1:0]  r;
        logic [ColW-1:0]  c;
        logic [QwdW-1:0]  w;
        b = rowBank[i] + BankW'(k);
        r = rowRow[i] + RowW'(k * 7);
        c = rowCol[i] + ColW'(k * 4);
        robQ.push_back({13'd0, rowOp[i], b, r, c});
        if (rowOp[i] == OpWrite) begin
            w = bufWord[c[6:2]];
            sdramChecker_i.expectCmd(4'b0011, b, r, '0, '0);                 // ACT
            sdramChecker_i.expectCmd(4'b0100, b, {3'd0, c}, w[35:4], w[3:0]); // WR
            sdramChecker_i.expectCmd(4'b0010, b, PreAllAddr, '0, '0);        // PRE
        end
    endtask

    task automatic drainWait();
        @(posedge sclk);
        while (robQ.size() != 0 || sdramChecker_i.pending() != 0) @(posedge sclk);
    endtask

    // ROB word appears the cycle after robRd and lasts one cycle
    always @(negedge sclk) begin
        if (robDue && robQ.size() != 0) begin
            robRdData <= robQ.pop_front();
        end else begin
            robRdData <= '0;
        end
        robDue   <= robRd;
        robEmpty <= (robQ.size() == 0);
    end

    // Buffer word appears the cycle after qwdRd and lasts one cycle
    always @(negedge sclk) begin
        qwdRdData <= qwdDue ? bufWord[qwdAddrHeld] : '0;
        qwdDue    <= qwdRd;
        if (qwdRd) qwdAddrHeld <= qwdRdAddr;
    end

    always @(negedge sclk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles with %0d commands still expected",
                     cycles, sdramChecker_i.pending());
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] lcg;
        logic [31:0] data;
        int          total;
        sclk      = 1'b0;
        sresetn   = 1'b0;
        robEmpty  = 1'b1;
        robRdData = '0;
        qwdRdData = '0;
        lcg = 32'd31;
        for (int a = 0; a < 32; a++) begin
            lcg  = lcgNext(lcg);
            data = lcg;
            lcg  = lcgNext(lcg);
            bufWord[a] = {data, lcg[19:16]};
        end
        setRow(0, "single",     1,   2'b01, 2'd1, 11'h123, 8'h5c);
        setRow(1, "backToBack", 3,   2'b01, 2'd2, 11'h010, 8'h04);
        setRow(2, "burst",      28,  2'b01, 2'd0, 11'h200, 8'h00);  // Overfills the queue
        setRow(3, "dropped",    1,   2'b01, 2'd3, 11'h055, 8'h10);
        setRow(4, "dropped",    2,   2'b10, 2'd1, 11'h066, 8'h20);
        setRow(5, "dropped",    1,   2'b00, 2'd2, 11'h077, 8'h30);
        setRow(6, "dropped",    1,   2'b11, 2'd0, 11'h088, 8'h40);
        setRow(7, "dropped",    1,   2'b01, 2'd1, 11'h099, 8'h50);
        setRow(8, "refresh",    700, 2'b01, 2'd0, 11'h300, 8'h08);  // Spans two tRefi
        total = 0;
        for (int i = 0; i < NumRows; i++)
            total += rowCount[i] * ((rowOp[i] == OpWrite) ? SeqCycles : PopCycles);
        limit = total + 2 * tRefi + 100;

        sdramChecker_i.beginTest("reset");
        sdramChecker_i.expectCmd(4'b0010, 2'd0, PreAllAddr, '0, '0);  // Precharge all
        repeat (2) @(negedge sclk);
        sresetn <= 1'b1;
        drainWait();
        sdramChecker_i.endTest();

        for (int i = 0; i < NumRows; i++) begin
            if (i == 0 || rowName[i] != rowName[i-1]) sdramChecker_i.beginTest(rowName[i]);
            @(posedge sclk);
            for (int k = 0; k < rowCount[i]; k++) sendRequest(i, k);
            if (i == NumRows - 1 || rowName[i+1] != rowName[i]) begin
                drainWait();
                if (rowName[i] == "refresh" && sdramChecker_i.refreshTotal() < 2)
                    sdramChecker_i.reportFailure("fewer than two refreshes seen");
                sdramChecker_i.endTest();
            end
        end
        repeat (2 * SeqCycles) @(negedge sclk);  // Catch stray commands

        sdramChecker_i.printSummary();
        if (sdramChecker_i.errorTotal() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/sdramPkg.sv
hw/sdramCmdIf.sv
hw/requestFetch.sv
hw/cmdQueue.sv
hw/accessSequencer.sv
hw/pinEncoder.sv
hw/sdramCmdGen.sv
dv/sdramChecker.sv
dv/tbSdramCmdGen.sv

// ==== Makefile ====
# Verilator flow for the SDRAM write command generator
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tbSdramCmdGen
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
